/* common/fpcmp_pkg.sv */
package fpcmp_pkg;

    // Operand and tag widths
    localparam int FP_W    = 32;
    localparam int TAG_W   = 4;
    localparam int CLASS_W = 10;

    // Credits on both sides of the unit
    localparam int IN_CREDITS  = 4;
    localparam int OUT_CREDITS = 2;

    // Request queue holds exactly one entry per input credit
    localparam int Q_DEPTH = IN_CREDITS;
    localparam int QPTR_W  = $clog2(Q_DEPTH);

    // Output credit counter must reach OUT_CREDITS
    localparam int CNT_W = $clog2(OUT_CREDITS + 1);

    // Quiet NaN for min/max with two NaN operands
    localparam logic [FP_W-1:0] CANON_NAN = 32'h7FC0_0000;

    typedef enum logic [2:0] {
        OP_EQ,
        OP_LT,
        OP_LE,
        OP_MIN,
        OP_MAX,
        OP_CLASS
    } fp_op_e;

    typedef enum logic [1:0] {
        ST_INIT,      // Counter loads OUT_CREDITS
        ST_IDLE,
        ST_ISSUE,
        ST_NO_CREDIT  // Queue waiting on output credit
    } issue_state_e;

    // Exactly one of these is set for any pair of operands
    typedef struct packed {
        logic eq;
        logic gt;
        logic lt;
        logic unordered;
    } cmp_flags_t;

endpackage

/* common/fpcmp_req_if.sv */
`timescale 1ns/1ps

interface fpcmp_req_if;
    import fpcmp_pkg::*;

    logic             valid;  // Queue not empty
    fp_op_e           op;
    logic [FP_W-1:0]  a;
    logic [FP_W-1:0]  b;
    logic [TAG_W-1:0] tag;
    logic             pop;    // Head leaves the queue

    // Queue side
    modport src (output valid, output op, output a, output b, output tag, input pop);

    // Executor side
    modport dst (input valid, input op, input a, input b, input tag);

    // Issue control watches the head and pops it
    modport mon (input valid, output pop);

endinterface

/* fp_comparator/fp_comparator.sv */
`timescale 1ns/1ps

module fp_comparator (
    input  logic [fpcmp_pkg::FP_W-1:0]    a,
    input  logic [fpcmp_pkg::FP_W-1:0]    b,
    output fpcmp_pkg::cmp_flags_t         flags,
    output logic [fpcmp_pkg::CLASS_W-1:0] a_class
);
    logic        a_sign;
    logic        b_sign;
    logic [7:0]  a_exp;
    logic [7:0]  b_exp;
    logic [22:0] a_mant;
    logic [22:0] b_mant;
    logic [30:0] a_mag;
    logic [30:0] b_mag;
    logic        a_zero;
    logic        b_zero;
    logic        a_inf;
    logic        a_nan;
    logic        b_nan;
    logic        a_sub;

    assign a_sign = a[31];
    assign b_sign = b[31];
    assign a_exp  = a[30:23];
    assign b_exp  = b[30:23];
    assign a_mant = a[22:0];
    assign b_mant = b[22:0];
    assign a_mag  = a[30:0];  // Exponent above mantissa orders by magnitude
    assign b_mag  = b[30:0];

    assign a_zero = (a_exp == 8'h00) && (a_mant == '0);
    assign b_zero = (b_exp == 8'h00) && (b_mant == '0);
    assign a_inf  = (a_exp == 8'hFF) && (a_mant == '0);
    assign a_nan  = (a_exp == 8'hFF) && (a_mant != '0);
    assign b_nan  = (b_exp == 8'hFF) && (b_mant != '0);
    assign a_sub  = (a_exp == 8'h00) && (a_mant != '0);

    always_comb begin
        flags = '0;
        if (a_nan || b_nan) begin
            flags.unordered = 1'b1;
        end else if ((a == b) || (a_zero && b_zero)) begin
            flags.eq = 1'b1;  // Also covers +0 against -0
        end else if (a_sign != b_sign) begin
            flags.lt = a_sign;
            flags.gt = b_sign;
        end else if (!a_sign) begin
            flags.gt = (a_mag > b_mag);
            flags.lt = (a_mag < b_mag);
        end else begin
            // Both negative so larger magnitude is smaller
            flags.gt = (a_mag < b_mag);
            flags.lt = (a_mag > b_mag);
        end
    end

    // One-hot class of operand a
    always_comb begin
        a_class = '0;
        if (a_nan && a_mant[22]) begin
            a_class[9] = 1'b1;  // Quiet NaN
        end else if (a_nan) begin
            a_class[8] = 1'b1;  // Signaling NaN
        end else if (a_inf) begin
            a_class[a_sign ? 0 : 7] = 1'b1;
        end else if (a_zero) begin
            a_class[a_sign ? 3 : 4] = 1'b1;
        end else if (a_sub) begin
            a_class[a_sign ? 2 : 5] = 1'b1;
        end else begin
            a_class[a_sign ? 1 : 6] = 1'b1;
        end
    end

    always_comb begin
        if (!$isunknown({a, b})) begin
            a_flags_onehot: assert final ($onehot(flags))
                else $error("comparator flags not one-hot: %b", flags);
        end
    end

endmodule

/* src/req_fifo.sv */
`timescale 1ns/1ps

module req_fifo (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        push,
    input  fpcmp_pkg::fp_op_e           push_op,
    input  logic [fpcmp_pkg::FP_W-1:0]  push_a,
    input  logic [fpcmp_pkg::FP_W-1:0]  push_b,
    input  logic [fpcmp_pkg::TAG_W-1:0] push_tag,
    fpcmp_req_if.src                    deq
);
    import fpcmp_pkg::*;

    fp_op_e           op_mem  [Q_DEPTH];
    logic [FP_W-1:0]  a_mem   [Q_DEPTH];
    logic [FP_W-1:0]  b_mem   [Q_DEPTH];
    logic [TAG_W-1:0] tag_mem [Q_DEPTH];

    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QPTR_W:0]   count;
    logic              full;

    assign full = (count == Q_DEPTH);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;  // Wraps at the depth
            if (deq.pop) rd_ptr <= rd_ptr + 1'b1;
            if (push && !deq.pop) begin
                count <= count + 1'b1;
            end else if (deq.pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            op_mem[wr_ptr]  <= push_op;
            a_mem[wr_ptr]   <= push_a;
            b_mem[wr_ptr]   <= push_b;
            tag_mem[wr_ptr] <= push_tag;
        end
    end

    // Head of queue
    assign deq.valid = (count != '0);
    assign deq.op    = op_mem[rd_ptr];
    assign deq.a     = a_mem[rd_ptr];
    assign deq.b     = b_mem[rd_ptr];
    assign deq.tag   = tag_mem[rd_ptr];

    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        push |-> !full)
        else $error("push into a full queue, input credit violated");

endmodule

/* src/credit_counter.sv */
`timescale 1ns/1ps

module credit_counter (
    input  logic clk,
    input  logic arst_n,
    input  logic load,
    input  logic take,
    input  logic give,
    output logic available
);
    import fpcmp_pkg::*;

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (load) begin
            count <= CNT_W'(OUT_CREDITS);
        end else if (take && !give) begin
            count <= count - 1'b1;
        end else if (give && !take) begin
            count <= count + 1'b1;
        end
    end

    // A credit returning this cycle can be spent at once
    assign available = (count != '0) || give;

    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
        (take && !give) |-> (count != '0))
        else $error("output credit underflow");

    a_no_excess: assert property (@(posedge clk) disable iff (!arst_n)
        count <= OUT_CREDITS)
        else $error("more output credits than OUT_CREDITS");

endmodule

/* src/issue_ctrl.sv */
`timescale 1ns/1ps

module issue_ctrl (
    input  logic     clk,
    input  logic     arst_n,
    fpcmp_req_if.mon q,
    input  logic     available,
    output logic     load,
    output logic     issue,
    output logic     in_credit
);
    import fpcmp_pkg::*;

    issue_state_e state;
    issue_state_e state_nxt;
    logic         go;

    assign go = q.valid && available;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_INIT;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        load      = 1'b0;
        issue     = 1'b0;
        state_nxt = state;
        case (state)
            ST_INIT: begin
                load      = 1'b1;  // Counter fills during this cycle
                state_nxt = ST_IDLE;
            end
            ST_IDLE, ST_ISSUE, ST_NO_CREDIT: begin
                issue = go;
                if (go) begin
                    state_nxt = ST_ISSUE;
                end else if (q.valid) begin
                    state_nxt = ST_NO_CREDIT;  // Head stalls on output credit
                end else begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_INIT;
        endcase
    end

    // Head leaves the queue and its credit goes back upstream
    assign q.pop     = issue;
    assign in_credit = issue;

endmodule

/* src/fp_op_exec.sv */
`timescale 1ns/1ps

module fp_op_exec (
    input  logic                        clk,
    input  logic                        arst_n,
    fpcmp_req_if.dst                    req,
    input  logic                        issue,
    output logic                        res_valid,
    output logic [fpcmp_pkg::FP_W-1:0]  res_data,
    output logic [fpcmp_pkg::TAG_W-1:0] res_tag,
    output logic                        res_invalid
);
    import fpcmp_pkg::*;

    cmp_flags_t         flags;
    logic [CLASS_W-1:0] a_class;
    logic               a_nan;
    logic               a_snan;
    logic               b_nan;
    logic               b_snan;
    logic [FP_W-1:0]    min_val;
    logic [FP_W-1:0]    max_val;
    logic [FP_W-1:0]    result;
    logic               invalid;

    fp_comparator u_cmp (
        .a       (req.a),
        .b       (req.b),
        .flags   (flags),
        .a_class (a_class)
    );

    // NaN of a comes from the class mask
    assign a_snan = a_class[8];
    assign a_nan  = a_class[8] | a_class[9];
    assign b_nan  = (req.b[30:23] == 8'hFF) && (req.b[22:0] != '0);
    assign b_snan = b_nan && !req.b[22];

    always_comb begin
        if (a_nan && b_nan) begin
            min_val = CANON_NAN;
            max_val = CANON_NAN;
        end else if (a_nan) begin
            min_val = req.b;  // Single NaN yields the other operand
            max_val = req.b;
        end else if (b_nan) begin
            min_val = req.a;
            max_val = req.a;
        end else if (flags.eq) begin
            // Only signed zeros differ here
            min_val = req.a[31] ? req.a : req.b;
            max_val = req.a[31] ? req.b : req.a;
        end else if (flags.lt) begin
            min_val = req.a;
            max_val = req.b;
        end else begin
            min_val = req.b;
            max_val = req.a;
        end
    end

    always_comb begin
        result  = '0;
        invalid = a_snan || b_snan;
        case (req.op)
            OP_EQ:    result[0] = flags.eq;
            OP_LT: begin
                result[0] = flags.lt;
                invalid   = flags.unordered;  // Signaling compare
            end
            OP_LE: begin
                result[0] = flags.lt | flags.eq;
                invalid   = flags.unordered;
            end
            OP_MIN:   result = min_val;
            OP_MAX:   result = max_val;
            OP_CLASS: begin
                result  = {{(FP_W-CLASS_W){1'b0}}, a_class};
                invalid = 1'b0;
            end
            default:  result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            res_data    <= result;
            res_tag     <= req.tag;
            res_invalid <= invalid;
        end
    end

    a_issue_has_head: assert property (@(posedge clk) disable iff (!arst_n)
        issue |-> req.valid)
        else $error("issue with an empty queue");

    a_tag_known: assert property (@(posedge clk) disable iff (!arst_n)
        res_valid |-> !$isunknown(res_tag))
        else $error("result with unknown tag");

endmodule

/* src/fpcmp_top.sv */
`timescale 1ns/1ps

module fpcmp_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        req_valid,
    input  fpcmp_pkg::fp_op_e           req_op,
    input  logic [fpcmp_pkg::FP_W-1:0]  req_a,
    input  logic [fpcmp_pkg::FP_W-1:0]  req_b,
    input  logic [fpcmp_pkg::TAG_W-1:0] req_tag,
    output logic                        in_credit,
    output logic                        res_valid,
    output logic [fpcmp_pkg::FP_W-1:0]  res_data,
    output logic [fpcmp_pkg::TAG_W-1:0] res_tag,
    output logic                        res_invalid,
    input  logic                        res_credit
);
    logic issue;
    logic load;
    logic available;

    fpcmp_req_if q_if ();

    req_fifo u_fifo (
        .clk      (clk),
        .arst_n   (arst_n),
        .push     (req_valid),
        .push_op  (req_op),
        .push_a   (req_a),
        .push_b   (req_b),
        .push_tag (req_tag),
        .deq      (q_if.src)
    );

    issue_ctrl u_issue (
        .clk       (clk),
        .arst_n    (arst_n),
        .q         (q_if.mon),
        .available (available),
        .load      (load),
        .issue     (issue),
        .in_credit (in_credit)
    );

    credit_counter u_credit (
        .clk       (clk),
        .arst_n    (arst_n),
        .load      (load),
        .take      (issue),
        .give      (res_credit),  // Downstream returns consumed results
        .available (available)
    );

    fp_op_exec u_exec (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (q_if.dst),
        .issue       (issue),
        .res_valid   (res_valid),
        .res_data    (res_data),
        .res_tag     (res_tag),
        .res_invalid (res_invalid)
    );

endmodule

/* verification/fpcmp_vectors.svh */
`ifndef FPCMP_VECTORS_SVH
`define FPCMP_VECTORS_SVH

    // Each row is opcode, operand a, operand b, expected data and expected invalid
    task automatic load_vectors();
        // Ordered compares of normals and subnormals
        add_vec(OP_EQ,    32'h3F80_0000, 32'h3F80_0000, 32'h0000_0001, 1'b0);
        add_vec(OP_EQ,    32'h3F80_0000, 32'h4000_0000, 32'h0000_0000, 1'b0);
        add_vec(OP_LT,    32'h3F80_0000, 32'h4000_0000, 32'h0000_0001, 1'b0);
        add_vec(OP_LT,    32'h4000_0000, 32'h3F80_0000, 32'h0000_0000, 1'b0);
        add_vec(OP_LT,    32'hBF80_0000, 32'h3F80_0000, 32'h0000_0001, 1'b0);
        add_vec(OP_LT,    32'hC000_0000, 32'hBF80_0000, 32'h0000_0001, 1'b0);
        add_vec(OP_LE,    32'hBF80_0000, 32'hBF80_0000, 32'h0000_0001, 1'b0);
        add_vec(OP_LE,    32'hBF80_0000, 32'hC000_0000, 32'h0000_0000, 1'b0);
        add_vec(OP_EQ,    32'h0000_0000, 32'h8000_0000, 32'h0000_0001, 1'b0);  // +0 == -0
        add_vec(OP_LT,    32'h8000_0000, 32'h0000_0000, 32'h0000_0000, 1'b0);
        add_vec(OP_LE,    32'h8000_0000, 32'h0000_0000, 32'h0000_0001, 1'b0);
        add_vec(OP_LT,    32'h0000_0001, 32'h0040_0000, 32'h0000_0001, 1'b0);
        add_vec(OP_LT,    32'h0040_0000, 32'h0080_0000, 32'h0000_0001, 1'b0);
        add_vec(OP_LT,    32'h8000_0001, 32'h0000_0000, 32'h0000_0001, 1'b0);
        add_vec(OP_LT,    32'hFF80_0000, 32'h7F80_0000, 32'h0000_0001, 1'b0);  // Infinities
        add_vec(OP_EQ,    32'h7F80_0000, 32'h7F80_0000, 32'h0000_0001, 1'b0);
        add_vec(OP_LE,    32'h7F7F_FFFF, 32'h7F80_0000, 32'h0000_0001, 1'b0);
        // Unordered
        add_vec(OP_EQ,    32'h7FC0_0000, 32'h3F80_0000, 32'h0000_0000, 1'b0);
        add_vec(OP_LT,    32'h3F80_0000, 32'h7FC0_0000, 32'h0000_0000, 1'b1);
        add_vec(OP_LE,    32'h7FC0_0000, 32'h7FC0_0000, 32'h0000_0000, 1'b1);
        add_vec(OP_EQ,    32'h7F80_0001, 32'h3F80_0000, 32'h0000_0000, 1'b1);  // Signaling
        add_vec(OP_EQ,    32'h3F80_0000, 32'hFFA0_0000, 32'h0000_0000, 1'b1);
        // Minimum and maximum
        add_vec(OP_MIN,   32'h3F80_0000, 32'h4000_0000, 32'h3F80_0000, 1'b0);
        add_vec(OP_MAX,   32'h3F80_0000, 32'h4000_0000, 32'h4000_0000, 1'b0);
        add_vec(OP_MIN,   32'hBF80_0000, 32'hC000_0000, 32'hC000_0000, 1'b0);
        add_vec(OP_MAX,   32'hFF80_0000, 32'hBF80_0000, 32'hBF80_0000, 1'b0);
        add_vec(OP_MIN,   32'h7FC0_0000, 32'h4000_0000, 32'h4000_0000, 1'b0);
        add_vec(OP_MAX,   32'hC000_0000, 32'h7FC0_0000, 32'hC000_0000, 1'b0);
        add_vec(OP_MIN,   32'h7FC0_0000, 32'h7FC0_0001, 32'h7FC0_0000, 1'b0);
        add_vec(OP_MAX,   32'h7F80_0001, 32'h7FC0_0000, 32'h7FC0_0000, 1'b1);
        add_vec(OP_MIN,   32'h7F80_0001, 32'h3F80_0000, 32'h3F80_0000, 1'b1);
        add_vec(OP_MIN,   32'h0000_0000, 32'h8000_0000, 32'h8000_0000, 1'b0);
        add_vec(OP_MAX,   32'h8000_0000, 32'h0000_0000, 32'h0000_0000, 1'b0);
        // One classify row per class bit
        add_vec(OP_CLASS, 32'hFF80_0000, 32'h0000_0000, 32'h0000_0001, 1'b0);
        add_vec(OP_CLASS, 32'hBF80_0000, 32'h0000_0000, 32'h0000_0002, 1'b0);
        add_vec(OP_CLASS, 32'h8000_0001, 32'h0000_0000, 32'h0000_0004, 1'b0);
        add_vec(OP_CLASS, 32'h8000_0000, 32'h0000_0000, 32'h0000_0008, 1'b0);
        add_vec(OP_CLASS, 32'h0000_0000, 32'h0000_0000, 32'h0000_0010, 1'b0);
        add_vec(OP_CLASS, 32'h0000_0001, 32'h0000_0000, 32'h0000_0020, 1'b0);
        add_vec(OP_CLASS, 32'h3F80_0000, 32'h0000_0000, 32'h0000_0040, 1'b0);
        add_vec(OP_CLASS, 32'h7F80_0000, 32'h0000_0000, 32'h0000_0080, 1'b0);
        add_vec(OP_CLASS, 32'h7F80_0001, 32'h0000_0000, 32'h0000_0100, 1'b0);
        add_vec(OP_CLASS, 32'h7FC0_0000, 32'h0000_0000, 32'h0000_0200, 1'b0);
    endtask

`endif

/* verification/tb_fpcmp.sv */
`timescale 1ns/1ps

module tb_fpcmp;
    import fpcmp_pkg::*;

    localparam int TIMEOUT = 200;  // Cycles per wait

    logic             clk;
    logic             arst_n;
    logic             req_valid;
    fp_op_e           req_op;
    logic [FP_W-1:0]  req_a;
    logic [FP_W-1:0]  req_b;
    logic [TAG_W-1:0] req_tag;
    logic             in_credit;
    logic             res_valid;
    logic [FP_W-1:0]  res_data;
    logic [TAG_W-1:0] res_tag;
    logic             res_invalid;
    logic             res_credit;

    fp_op_e          vec_op[$];
    logic [FP_W-1:0] vec_a[$];
    logic [FP_W-1:0] vec_b[$];
    logic [FP_W-1:0] vec_exp[$];
    logic            vec_inv[$];

    int        in_cred = IN_CREDITS;  // Upstream view of input credits
    int        in_pulses = 0;
    int        n_res = 0;
    int        n_ret = 0;  // Output credits given back
    int        n_pass = 0;
    int        n_fail = 0;
    int        cyc = 0;
    int        ret_q[$];   // Cycles at which downstream returns a credit
    logic [31:0] rng = 32'h6d22_7b5c;
    bit        timed_out;
    bit        bad;

    fpcmp_top UUT (
        .clk(clk), .arst_n(arst_n), .req_valid(req_valid), .req_op(req_op),
        .req_a(req_a), .req_b(req_b), .req_tag(req_tag), .in_credit(in_credit),
        .res_valid(res_valid), .res_data(res_data), .res_tag(res_tag),
        .res_invalid(res_invalid), .res_credit(res_credit)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_vec(input fp_op_e op, input logic [FP_W-1:0] a,
                           input logic [FP_W-1:0] b, input logic [FP_W-1:0] exp_data,
                           input logic exp_inv);
        vec_op.push_back(op);
        vec_a.push_back(a);
        vec_b.push_back(b);
        vec_exp.push_back(exp_data);
        vec_inv.push_back(exp_inv);
    endtask

    `include "fpcmp_vectors.svh"

    task automatic check_result();
        int idx;
        bit err;
        idx = n_res;
        err = 1'b0;
        n_res++;
        assert (idx < vec_a.size())
            else begin
                $display("Result with tag %0d arrived after the whole table", res_tag);
                n_fail++;
            end
        if (idx < vec_a.size()) begin
            assert (res_tag == TAG_W'(idx))
                else begin
                    $display("FAILED at %0t: row %0d tag %0d", $time, idx, res_tag);
                    err = 1'b1;
                end
            assert (res_data == vec_exp[idx])
                else begin
                    $display("FAILED at %0t: row %0d data %h, expected %h",
                             $time, idx, res_data, vec_exp[idx]);
                    err = 1'b1;
                end
            assert (res_invalid == vec_inv[idx])
                else begin
                    $display("FAILED at %0t: row %0d invalid %b, expected %b",
                             $time, idx, res_invalid, vec_inv[idx]);
                    err = 1'b1;
                end
            assert (n_res - n_ret <= OUT_CREDITS)
                else begin
                    $display("FAILED at %0t: %0d results ahead of returned credits",
                             $time, n_res - n_ret);
                    err = 1'b1;
                end
            if (err) n_fail++;
            else n_pass++;
            $display("Row %0d tag %0d: %s", idx, res_tag, err ? "fail" : "pass");
        end
    endtask

    // Result monitor and downstream credit model
    always @(posedge clk) begin
        cyc++;
        if (arst_n) begin
            if (in_credit) begin
                in_cred++;
                in_pulses++;
            end
            if (res_valid) begin
                check_result();
                rng = lcg_next(rng);
                ret_q.push_back(cyc + int'(rng[31:16] % 16'd6));  // Gap of 0 to 5
            end
            if (res_credit) n_ret++;
        end
        #1;
        res_credit = 1'b0;
        if (ret_q.size() > 0 && ret_q[0] <= cyc) begin
            res_credit = 1'b1;
            void'(ret_q.pop_front());
        end
    end

    // Sends the table in bursts as input credits allow
    task automatic send_all(output bit tmo);
        int wait_cyc;
        tmo = 1'b0;
        for (int i = 0; i < vec_a.size() && !tmo; i++) begin
            wait_cyc = 0;
            while (in_cred == 0 && wait_cyc < TIMEOUT) begin
                req_valid = 1'b0;
                @(posedge clk);
                #1;
                wait_cyc++;
            end
            if (in_cred == 0) begin
                $display("Timeout: no input credit came back while sending row %0d", i);
                tmo = 1'b1;
            end else begin
                req_valid = 1'b1;
                req_op    = vec_op[i];
                req_a     = vec_a[i];
                req_b     = vec_b[i];
                req_tag   = TAG_W'(i);
                in_cred--;
                @(posedge clk);
                #1;
            end
        end
        req_valid = 1'b0;
    endtask

    task automatic wait_results(output bit tmo);
        int wait_cyc;
        wait_cyc = 0;
        while (n_res < vec_a.size() && wait_cyc < TIMEOUT) begin
            @(posedge clk);
            #1;
            wait_cyc++;
        end
        tmo = (n_res < vec_a.size());
        if (tmo) $display("Timeout: only %0d of %0d results arrived", n_res, vec_a.size());
    endtask

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        req_valid  = 1'b0;
        req_op     = OP_EQ;
        req_a      = '0;
        req_b      = '0;
        req_tag    = '0;
        res_credit = 1'b0;
        load_vectors();
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Outputs stay quiet until the first request
        bad = 1'b0;
        repeat (3) begin
            @(posedge clk);
            assert (!res_valid && !in_credit)
                else begin
                    $display("Output active after reset with no request sent");
                    bad = 1'b1;
                end
        end
        if (bad) n_fail++;
        else n_pass++;
        $display("Reset: %s", bad ? "fail" : "pass");
        #1;

        send_all(timed_out);
        if (!timed_out) wait_results(timed_out);

        bad = 1'b0;
        assert (in_pulses == vec_a.size() && in_cred == IN_CREDITS)
            else begin
                $display("FAILED at %0t: %0d in_credit pulses for %0d requests",
                         $time, in_pulses, vec_a.size());
                bad = 1'b1;
            end
        if (bad) n_fail++;
        else n_pass++;
        $display("Input credits: %s", bad ? "fail" : "pass");

        $display("Summary: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+verification
common/fpcmp_pkg.sv
common/fpcmp_req_if.sv
fp_comparator/fp_comparator.sv
src/req_fifo.sv
src/credit_counter.sv
src/issue_ctrl.sv
src/fp_op_exec.sv
src/fpcmp_top.sv
verification/tb_fpcmp.sv
